//--- rtl/v_sldu_pkg.sv
/*
 * Shared types for the vector slide unit: opcodes, legalised element width
 * and register-group codes, the decoded control word, and the two views of
 * the rs1 scalar word. Modules pull these in with a wildcard import.
 */
`default_nettype none

package v_sldu_pkg;

    localparam int XLEN     = 32;   // scalar word width
    localparam int OFFSET_W = 7;    // slide offset taken from rs1

    // valu opcodes handled here, anything else is a scalar move
    typedef enum logic [5:0] {
        VSLIDEUP    = 6'd14,
        VSLIDEDOWN  = 6'd15,
        VSLIDE1UP   = 6'd30,
        VSLIDE1DOWN = 6'd31
    } sldu_op_e;

    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } eew_e;

    typedef enum logic [1:0] {
        GROUP_1 = 2'd0,   // one register
        GROUP_2 = 2'd1,
        GROUP_4 = 2'd2
    } group_e;

    typedef enum logic [1:0] {
        DIR_UP   = 2'd0,
        DIR_DOWN = 2'd1,
        DIR_MOVE = 2'd2
    } slide_dir_e;

    typedef struct packed {
        slide_dir_e dir;
        logic       slide1;   // shift by one and insert the scalar
        eew_e       eew;
        group_e     group;
    } sldu_ctrl_t;

    // rs1 read either as a slide offset or as the scalar to insert
    typedef union packed {
        struct packed {
            logic [XLEN-OFFSET_W-1:0] ignored;
            logic [OFFSET_W-1:0]      offset;
        } off;
        logic [XLEN-1:0] scalar;
    } scalar_word_u;

    // log2 of the element width in bits
    function automatic int unsigned eew_log2(eew_e eew);
        case (eew)
            EEW_16:  return 4;
            EEW_32:  return 5;
            default: return 3;
        endcase
    endfunction

    // scalar cut down to one element, upper bits zero
    function automatic logic [XLEN-1:0] eew_scalar(scalar_word_u word, eew_e eew);
        logic [XLEN-1:0] mask;
        mask = {XLEN{1'b1}} >> (XLEN - (1 << eew_log2(eew)));
        return word.scalar & mask;
    endfunction

endpackage

`default_nettype wire

//--- rtl/sldu_decode.sv
/*
 * Opcode and vtype decode for the slide unit. Purely combinational; turns
 * op_instr, sew and lmul into the legalised control word used downstream.
 */
`timescale 1ns/1ps
`default_nettype none

module sldu_decode import v_sldu_pkg::*; (
    input  sldu_op_e   op_instr,
    input  logic [2:0] sew,
    input  logic [2:0] lmul,
    output sldu_ctrl_t ctrl
);

    always_comb begin
        case (op_instr)
            VSLIDEUP: begin
                ctrl.dir    = DIR_UP;
                ctrl.slide1 = 1'b0;
            end
            VSLIDE1UP: begin
                ctrl.dir    = DIR_UP;
                ctrl.slide1 = 1'b1;
            end
            VSLIDEDOWN: begin
                ctrl.dir    = DIR_DOWN;
                ctrl.slide1 = 1'b0;
            end
            VSLIDE1DOWN: begin
                ctrl.dir    = DIR_DOWN;
                ctrl.slide1 = 1'b1;
            end
            default: begin
                ctrl.dir    = DIR_MOVE;   // vmv, scalar to element 0
                ctrl.slide1 = 1'b0;
            end
        endcase

        case (sew)
            3'b001:  ctrl.eew = EEW_16;
            3'b010:  ctrl.eew = EEW_32;
            default: ctrl.eew = EEW_8;    // reserved codes run as e8
        endcase

        case (lmul)
            3'b001:  ctrl.group = GROUP_2;
            3'b010:  ctrl.group = GROUP_4;
            default: ctrl.group = GROUP_1;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/sldu_slide_up.sv
/*
 * Slide-up and slide1-up over the full four-register group. Elements below
 * the offset keep their source value; slide1 puts the scalar in element 0.
 * Combinational, one candidate for the result stage.
 */
`timescale 1ns/1ps
`default_nettype none

module sldu_slide_up import v_sldu_pkg::*; #(
    parameter int VLEN = 128   // bits per vector register
) (
    input  logic [4*VLEN-1:0] vs2_group,
    input  scalar_word_u      rs1,
    input  sldu_ctrl_t        ctrl,
    output logic [4*VLEN-1:0] slid
);

    localparam int VW = 4 * VLEN;
    localparam int AW = $clog2(VW);

    int unsigned         esh;       // log2 of element width
    int unsigned         n_elem;    // elements in four registers
    logic [OFFSET_W-1:0] step;
    logic [AW-1:0]       shamt;     // offset in bits
    logic [VW-1:0]       shifted;
    logic [VW-1:0]       low_keep;

    always_comb begin
        esh      = eew_log2(ctrl.eew);
        n_elem   = VW >> esh;
        step     = ctrl.slide1 ? OFFSET_W'(1) : rs1.off.offset;
        shamt    = AW'(step) << esh;
        shifted  = vs2_group << shamt;
        low_keep = vs2_group & ~({VW{1'b1}} << shamt);   // elements under the offset

        if (step >= n_elem) begin
            slid = vs2_group;   // nothing moves past the group
        end else if (ctrl.slide1) begin
            slid = shifted | VW'(eew_scalar(rs1, ctrl.eew));
        end else begin
            slid = shifted | low_keep;
        end
    end

endmodule

`default_nettype wire

//--- rtl/sldu_slide_down.sv
/*
 * Slide-down and slide1-down inside the register group picked by lmul.
 * The source is cut to the group first, so vacated elements and everything
 * above the group read as zero. slide1 writes the scalar into the group's
 * top element. Combinational.
 */
`timescale 1ns/1ps
`default_nettype none

module sldu_slide_down import v_sldu_pkg::*; #(
    parameter int VLEN = 128   // bits per vector register
) (
    input  logic [4*VLEN-1:0] vs2_group,
    input  scalar_word_u      rs1,
    input  sldu_ctrl_t        ctrl,
    output logic [4*VLEN-1:0] slid
);

    localparam int VW = 4 * VLEN;
    localparam int AW = $clog2(VW);

    int unsigned         esh;       // log2 of element width
    int unsigned         gsh;       // log2 of registers in the group
    int unsigned         g_bits;
    int unsigned         n_elem;    // elements in the group
    logic [OFFSET_W-1:0] step;
    logic [AW-1:0]       shamt;
    logic [AW-1:0]       top_pos;   // lsb of the top element
    logic [VW-1:0]       masked;
    logic [VW-1:0]       shifted;

    always_comb begin
        case (ctrl.group)
            GROUP_2: gsh = 1;
            GROUP_4: gsh = 2;
            default: gsh = 0;
        endcase

        esh     = eew_log2(ctrl.eew);
        g_bits  = VLEN << gsh;
        n_elem  = g_bits >> esh;
        step    = ctrl.slide1 ? OFFSET_W'(1) : rs1.off.offset;
        shamt   = AW'(step) << esh;
        top_pos = AW'(g_bits - (1 << esh));

        // drop registers outside the group, also at offset 0
        masked  = vs2_group & ({VW{1'b1}} >> (VW - g_bits));
        shifted = masked >> shamt;

        if (step >= n_elem) begin
            slid = '0;
        end else if (ctrl.slide1) begin
            slid = shifted | (VW'(eew_scalar(rs1, ctrl.eew)) << top_pos);
        end else begin
            slid = shifted;
        end
    end

endmodule

`default_nettype wire

//--- rtl/sldu_result_stage.sv
/*
 * Output stage of the slide unit. Builds the scalar-move word, selects the
 * up, down or move result by direction and registers it. This register is
 * the only state in the unit, giving one cycle of latency.
 */
`timescale 1ns/1ps
`default_nettype none

module sldu_result_stage import v_sldu_pkg::*; #(
    parameter int VLEN = 128   // bits per vector register
) (
    input  logic              clk,
    input  logic              rst_n,
    input  sldu_ctrl_t        ctrl,
    input  scalar_word_u      rs1,
    input  logic [4*VLEN-1:0] up_slid,
    input  logic [4*VLEN-1:0] down_slid,
    output logic [4*VLEN-1:0] result
);

    localparam int VW = 4 * VLEN;

    logic [VW-1:0] move_word;
    logic [VW-1:0] next_result;

    assign move_word = VW'(eew_scalar(rs1, ctrl.eew));   // scalar at element 0

    always_comb begin
        case (ctrl.dir)
            DIR_UP:   next_result = up_slid;
            DIR_DOWN: next_result = down_slid;
            default:  next_result = move_word;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result <= next_result;
        end
    end

endmodule

`default_nettype wire

//--- rtl/v_sldu.sv
/*
 * Vector slide unit top level. Takes a four-register vs2 group and the rs1
 * scalar, performs slide-up/down, slide1-up/down or scalar move, and
 * presents the result one clock after the operands. No handshake.
 */
`timescale 1ns/1ps
`default_nettype none

module v_sldu import v_sldu_pkg::*; #(
    parameter int VLEN = 128   // bits per vector register
) (
    input  logic              clk,
    input  logic              rst_n,
    input  sldu_op_e          op_instr,
    input  logic [2:0]        sew,
    input  logic [2:0]        lmul,
    input  logic [4*VLEN-1:0] vs2_group,   // vs2 in the low register
    input  scalar_word_u      rs1,
    output logic [4*VLEN-1:0] result
);

    sldu_ctrl_t        ctrl;
    logic [4*VLEN-1:0] up_slid;
    logic [4*VLEN-1:0] down_slid;

    sldu_decode u_decode (
        .op_instr (op_instr),
        .sew      (sew),
        .lmul     (lmul),
        .ctrl     (ctrl)
    );

    sldu_slide_up #(.VLEN(VLEN)) u_slide_up (
        .vs2_group (vs2_group),
        .rs1       (rs1),
        .ctrl      (ctrl),
        .slid      (up_slid)
    );

    sldu_slide_down #(.VLEN(VLEN)) u_slide_down (
        .vs2_group (vs2_group),
        .rs1       (rs1),
        .ctrl      (ctrl),
        .slid      (down_slid)
    );

    sldu_result_stage #(.VLEN(VLEN)) u_result_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .rs1       (rs1),
        .up_slid   (up_slid),
        .down_slid (down_slid),
        .result    (result)
    );

endmodule

`default_nettype wire

//--- sim/v_sldu_assertions.sv
/*
 * Concurrent checks on the slide unit top level, attached with bind.
 * Covers reset clearing, known control inputs and the zeroed upper bits
 * of single-register slide-down and scalar-move results.
 */
`timescale 1ns/1ps
`default_nettype none

module v_sldu_assertions import v_sldu_pkg::*; #(
    parameter int VLEN = 128
) (
    input logic              clk,
    input logic              rst_n,
    input sldu_op_e          op_instr,
    input logic [2:0]        sew,
    input logic [2:0]        lmul,
    input logic [4*VLEN-1:0] result
);

    reset_clears_result: assert property (@(posedge clk) !rst_n |-> result == '0)
        else $error("result not zero while reset is low");

    ctrl_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({op_instr, sew, lmul}))
        else $error("unknown bits on op_instr, sew or lmul");

    // single register group leaves the upper three registers clear
    down_one_reg_upper_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (op_instr inside {VSLIDEDOWN, VSLIDE1DOWN}) && !(lmul inside {3'd1, 3'd2})
        |=> result[4*VLEN-1:VLEN] == '0)
        else $error("slide-down left bits above the one-register group");

    move_upper_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !(op_instr inside {VSLIDEUP, VSLIDEDOWN, VSLIDE1UP, VSLIDE1DOWN})
        |=> result[4*VLEN-1:XLEN] == '0)
        else $error("scalar move left bits above the scalar word");

endmodule

bind v_sldu v_sldu_assertions #(.VLEN(VLEN)) u_assertions (
    .clk      (clk),
    .rst_n    (rst_n),
    .op_instr (op_instr),
    .sew      (sew),
    .lmul     (lmul),
    .result   (result)
);

`default_nettype wire

//--- sim/v_sldu_tb.sv
/*
 * Directed testbench for the vector slide unit. Drives operations on the
 * rising edge, checks each result one cycle later against a reference
 * model of the slide rules, and stops at the first mismatch.
 */
`timescale 1ns/1ps
`default_nettype none

module v_sldu_tb import v_sldu_pkg::*;;

    localparam int VLEN = 128;
    localparam int VW   = 4 * VLEN;

    // cycles per test including one drain cycle per sweep
    localparam int N_RESET  = 5;
    localparam int N_UP     = 3 * 5 + 1;
    localparam int N_DOWN   = 4 * 3 * 5 + 1;
    localparam int N_SLIDE1 = 3 * 3 * 2 + 1;
    localparam int N_MOVE   = 2 + 1;
    localparam int N_B2B    = 8 + 1;
    localparam int TEST_CYCLES    = N_RESET + N_UP + N_DOWN + N_SLIDE1 + N_MOVE + N_B2B;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 20;

    typedef logic [VW-1:0] vec_t;

    logic         clk = 1'b0;
    logic         rst_n;
    sldu_op_e     op_instr;
    logic [2:0]   sew;
    logic [2:0]   lmul;
    vec_t         vs2_group;
    scalar_word_u rs1;
    vec_t         result;

    logic [15:0] lfsr = 16'd10481;
    int          cycles = 0;
    logic        pend;        // an operation waits for its check
    vec_t        pend_exp;
    string       pend_what;

    v_sldu #(.VLEN(VLEN)) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_instr  (op_instr),
        .sew       (sew),
        .lmul      (lmul),
        .vs2_group (vs2_group),
        .rs1       (rs1),
        .result    (result)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles", cycles);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
    endfunction

    task automatic random_vector(output vec_t v);
        int i;
        for (i = 0; i < VW; i++) begin
            lfsr = lfsr_step(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    task automatic random_word(output logic [31:0] w);
        int i;
        for (i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w[i] = lfsr[0];
        end
    endtask

    function automatic int elem_bits(input logic [2:0] sew_c);
        return (sew_c == 3'd1) ? 16 : (sew_c == 3'd2) ? 32 : 8;   // reserved as e8
    endfunction

    function automatic int group_regs(input logic [2:0] lmul_c);
        return (lmul_c == 3'd1) ? 2 : (lmul_c == 3'd2) ? 4 : 1;
    endfunction

    // element-wise reference of the slide rules
    function automatic vec_t model(input sldu_op_e op, input logic [2:0] sew_c,
                                   input logic [2:0] lmul_c, input vec_t src,
                                   input logic [31:0] word);
        int   w;
        int   n_full;
        int   n_grp;
        int   step;
        int   i;
        vec_t mask;
        vec_t elem;
        vec_t res;
        w      = elem_bits(sew_c);
        n_full = VW / w;
        n_grp  = group_regs(lmul_c) * VLEN / w;
        mask   = (vec_t'(1) << w) - vec_t'(1);
        step   = (op == VSLIDE1UP || op == VSLIDE1DOWN) ? 1 : int'(word[6:0]);
        res    = '0;
        if (op == VSLIDEUP || op == VSLIDE1UP) begin
            if (step >= n_full) begin
                res = src;
            end else begin
                for (i = 0; i < n_full; i++) begin
                    if (i >= step)
                        elem = (src >> ((i - step) * w)) & mask;
                    else if (op == VSLIDE1UP)
                        elem = vec_t'(word) & mask;
                    else
                        elem = (src >> (i * w)) & mask;   // below offset stays
                    res |= elem << (i * w);
                end
            end
        end else if (op == VSLIDEDOWN || op == VSLIDE1DOWN) begin
            if (step < n_grp) begin
                for (i = 0; i < n_grp; i++) begin
                    if (i + step < n_grp)
                        elem = (src >> ((i + step) * w)) & mask;
                    else if (op == VSLIDE1DOWN)
                        elem = vec_t'(word) & mask;   // top of group
                    else
                        elem = '0;
                    res |= elem << (i * w);
                end
            end
        end else begin
            res = vec_t'(word) & mask;   // scalar move
        end
        return res;
    endfunction

    task automatic check_result(input vec_t got, input vec_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s", $time, what);
            $display("  got      %h", got);
            $display("  expected %h", exp);
            $display("Test FAILED");
            $fatal(1, "result mismatch");
        end
    endtask

    // drive one operation and check the one before it
    task automatic issue(input sldu_op_e op, input logic [2:0] sew_c,
                         input logic [2:0] lmul_c, input vec_t src,
                         input logic [31:0] word, input string what);
        @(posedge clk);
        op_instr   <= op;
        sew        <= sew_c;
        lmul       <= lmul_c;
        vs2_group  <= src;
        rs1.scalar <= word;
        @(negedge clk);
        if (pend)
            check_result(result, pend_exp, pend_what);
        pend      = 1'b1;
        pend_exp  = model(op, sew_c, lmul_c, src, word);
        pend_what = what;
    endtask

    task automatic drain();
        @(posedge clk);
        @(negedge clk);
        if (pend)
            check_result(result, pend_exp, pend_what);
        pend = 1'b0;
    endtask

    // offsets 0, 1, middle, last legal and one past
    task automatic sweep_offsets(input sldu_op_e op, input logic [2:0] sew_c,
                                 input logic [2:0] lmul_c, input int n);
        int          k;
        int          offs[5];
        vec_t        src;
        logic [31:0] word;
        offs = '{0, 1, n / 2, n - 1, n};
        for (k = 0; k < 5; k++) begin
            random_vector(src);
            random_word(word);
            word[6:0] = 7'(offs[k]);
            issue(op, sew_c, lmul_c, src, word,
                  $sformatf("%s sew %0d lmul %0d offset %0d", op.name(), sew_c, lmul_c,
                            offs[k]));
        end
    endtask

    task automatic test_reset();
        int k;
        for (k = 0; k < 3; k++) begin
            @(negedge clk);
            check_result(result, '0, "result during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_result(result, '0, "result at reset release");
        @(posedge clk);
        @(negedge clk);
        check_result(result, '0, "result on first edge after release");
    endtask

    task automatic test_slide_up();
        int s;
        for (s = 0; s < 3; s++)
            sweep_offsets(VSLIDEUP, 3'(s), 3'(s), VW / elem_bits(3'(s)));
        drain();
    endtask

    task automatic test_slide_down();
        int         s;
        int         g;
        logic [2:0] codes[4];
        codes = '{3'd0, 3'd1, 3'd2, 3'd5};   // 5 is unrecognised and acts as one register
        for (g = 0; g < 4; g++)
            for (s = 0; s < 3; s++)
                sweep_offsets(VSLIDEDOWN, 3'(s), codes[g],
                              group_regs(codes[g]) * VLEN / elem_bits(3'(s)));
        drain();
    endtask

    task automatic test_slide1();
        int          s;
        int          g;
        vec_t        src;
        logic [31:0] word;
        for (s = 0; s < 3; s++) begin
            for (g = 0; g < 3; g++) begin
                random_vector(src);
                random_word(word);
                issue(VSLIDE1UP, 3'(s), 3'(g), src, word,
                      $sformatf("vslide1up sew %0d lmul %0d", s, g));
                random_vector(src);
                random_word(word);
                issue(VSLIDE1DOWN, 3'(s), 3'(g), src, word,
                      $sformatf("vslide1down sew %0d lmul %0d", s, g));
            end
        end
        drain();
    endtask

    task automatic test_scalar_move();
        vec_t        src;
        logic [31:0] word;
        random_vector(src);
        random_word(word);
        issue(sldu_op_e'(6'd0), 3'd2, 3'd1, src, word, "scalar move e32");
        random_vector(src);
        random_word(word);
        issue(sldu_op_e'(6'd7), 3'd3, 3'd2, src, word, "scalar move sew 3 as e8");
        drain();
    endtask

    task automatic test_back_to_back();
        int          k;
        vec_t        src;
        logic [31:0] word;
        sldu_op_e    ops[8];
        logic [2:0]  sews[8];
        logic [2:0]  lmuls[8];
        int          offs[8];
        ops   = '{VSLIDEUP, VSLIDEDOWN, sldu_op_e'(6'd45), VSLIDE1UP, VSLIDE1DOWN,
                  VSLIDEDOWN, VSLIDEUP, sldu_op_e'(6'd2)};
        sews  = '{3'd1, 3'd2, 3'd0, 3'd0, 3'd1, 3'd0, 3'd2, 3'd3};
        lmuls = '{3'd0, 3'd1, 3'd2, 3'd2, 3'd2, 3'd0, 3'd1, 3'd4};
        offs  = '{3, 2, 9, 0, 0, 5, 7, 1};
        for (k = 0; k < 8; k++) begin
            random_vector(src);
            random_word(word);
            word[6:0] = 7'(offs[k]);
            issue(ops[k], sews[k], lmuls[k], src, word,
                  $sformatf("back-to-back step %0d %s", k, ops[k].name()));
        end
        drain();
    endtask

    initial begin
        rst_n      = 1'b0;
        op_instr   = sldu_op_e'(6'd0);
        sew        = 3'd0;
        lmul       = 3'd0;
        vs2_group  = '0;
        rs1.scalar = '0;
        pend       = 1'b0;
        pend_exp   = '0;

        test_reset();
        test_slide_up();
        test_slide_down();
        test_slide1();
        test_scalar_move();
        test_back_to_back();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- v_sldu.f
rtl/v_sldu_pkg.sv
rtl/sldu_decode.sv
rtl/sldu_slide_up.sv
rtl/sldu_slide_down.sv
rtl/sldu_result_stage.sv
rtl/v_sldu.sv
sim/v_sldu_assertions.sv
sim/v_sldu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the slide unit testbench with Verilator and run it.
# Exit status is 0 only when the run printed the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module v_sldu_tb \
    -f v_sldu.f \
    -Mdir obj_dir \
    -o v_sldu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/v_sldu_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation did not report a pass"
    exit 1
fi
